//--- mdpx_defs.svh
`ifndef MDPX_DEFS_SVH
`define MDPX_DEFS_SVH

// width of the chip's operation mode register.
`define OMR_BITS 48

// DAC bank seen by the host.
`define DAC_COUNT 8
`define DAC_BITS 8

// the longest burst is the OMR followed by every DAC value.
`define FRAME_BITS 112

// holds any frame length up to FRAME_BITS.
`define LEN_BITS 7

`define N_CHANNELS 2

`endif

//--- medipix_pkg.sv
`include "mdpx_defs.svh"

package medipix_pkg;

  // operation mode register, most significant field first as shifted out.
  typedef struct packed {
    logic [2:0] m;
    logic       crw_srw;
    logic       polarity;
    logic [1:0] ps;
    logic       disc_csm_spm;
    logic       enable_tp;
    logic [1:0] count_l;
    logic [2:0] column_block;
    logic       column_blocksel;
    logic [2:0] row_block;
    logic       row_blocksel;
    logic       equalization;
    logic       colour_mode;
    logic       csm_spm;
    logic       info_header;
    logic [5:0] fuse_sel;
    logic [5:0] fuse_pulse_wd;
    logic [1:0] gain_mode;
    logic       sense_dac;
    logic       ext_dac;
    logic       ext_bg_sel;
    logic [7:0] reserved;
  } omr_t;

  typedef enum logic [2:0] {
    M_IDLE      = 3'b000,
    M_SET_OMR   = 3'b011,
    M_LOAD_DACS = 3'b100
  } m_code_t;

  // bits are left-aligned, only the first len of them go out.
  typedef struct packed {
    logic [`FRAME_BITS-1:0] bits;
    logic [`LEN_BITS-1:0]   len;
    m_code_t                m;
  } burst_frame_t;

endpackage

//--- nios_pkg.sv
package nios_pkg;

  // first byte of every host command, sent with sync high.
  typedef enum logic [7:0] {
    OP_OMR_WRITE = 8'h01,
    OP_DAC_WRITE = 8'h02,
    OP_DAC_LOAD  = 8'h03
  } opcode_t;

  typedef enum logic [1:0] {
    IDLE,
    OMR_BYTES,
    DAC_INDEX,
    DAC_VALUE
  } dec_state_t;

endpackage

//--- burst_if.sv
`timescale 1ns/1ns

interface burst_if ();

  logic                clk_mdpx;
  logic                data_mdpx;
  logic                en_mdpx;
  logic                busy;
  medipix_pkg::m_code_t m;

  modport channel (output clk_mdpx, output data_mdpx, output en_mdpx, output busy, output m);

  modport sink (input clk_mdpx, input data_mdpx, input en_mdpx, input busy, input m);

  // the decoder only needs to know whether a burst is running.
  modport monitor (input busy);

endinterface

//--- command_decoder.sv
`timescale 1ns/1ns
`include "mdpx_defs.svh"

module command_decoder (
  input  logic                      clk_nios,
  input  logic                      reset,
  input  logic                      en,
  input  logic                      sync,
  input  logic [7:0]                data,
  burst_if.monitor                  chan [`N_CHANNELS],
  output logic [`N_CHANNELS-1:0]    start,
  output medipix_pkg::burst_frame_t frame
);

  localparam int OMR_CH = 0;
  localparam int LOAD_CH = 1;
  localparam int OMR_LAST = `OMR_BITS / 8 - 1;
  localparam int IDX_BITS = $clog2(`DAC_COUNT);
  localparam int DAC_FLAT = `DAC_COUNT * `DAC_BITS;

  nios_pkg::dec_state_t          state;
  logic [$clog2(OMR_LAST+1)-1:0] byte_cnt;
  logic [`OMR_BITS-9:0]          omr_shift;
  medipix_pkg::omr_t             omr;
  logic [`DAC_BITS-1:0]          dac [`DAC_COUNT];
  logic [IDX_BITS-1:0]           dac_idx;
  logic [DAC_FLAT-1:0]           dac_flat;
  logic [`N_CHANNELS-1:0]        busy;
  logic [`N_CHANNELS-1:0]        go;
  logic                          blocked;

  genvar g;
  generate
    for (g = 0; g < `N_CHANNELS; g++) begin : g_busy
      assign busy[g] = chan[g].busy;
    end
  endgenerate

  // a launch still on its way to a channel counts as busy too.
  assign blocked = (|busy) | (|go) | (|start);

  always_ff @(posedge clk_nios) begin
    if (reset) begin
      state    <= nios_pkg::IDLE;
      byte_cnt <= '0;
      omr      <= '0;
      dac_idx  <= '0;
      go       <= '0;
      start    <= '0;
      for (int i = 0; i < `DAC_COUNT; i++) begin
        dac[i] <= '0;
      end
    end else begin
      go    <= '0;
      start <= go; // one cycle between acceptance and start.
      if (en && sync) begin
        byte_cnt <= '0;
        case (nios_pkg::opcode_t'(data))
          nios_pkg::OP_OMR_WRITE: state <= nios_pkg::OMR_BYTES;
          nios_pkg::OP_DAC_WRITE: state <= nios_pkg::DAC_INDEX;
          nios_pkg::OP_DAC_LOAD: begin
            state <= nios_pkg::IDLE;
            if (!blocked) begin
              go[LOAD_CH] <= 1'b1;
            end
          end
          default: state <= nios_pkg::IDLE; // unknown opcodes are ignored.
        endcase
      end else if (en) begin
        case (state)
          nios_pkg::OMR_BYTES: begin
            omr_shift <= {omr_shift[`OMR_BITS-17:0], data};
            if (byte_cnt == OMR_LAST) begin
              state <= nios_pkg::IDLE;
              // the register only takes the new value if the burst can go.
              if (!blocked) begin
                omr         <= {omr_shift, data};
                go[OMR_CH]  <= 1'b1;
              end
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          nios_pkg::DAC_INDEX: begin
            dac_idx <= data[IDX_BITS-1:0];
            state   <= nios_pkg::DAC_VALUE;
          end
          nios_pkg::DAC_VALUE: begin
            dac[dac_idx] <= data;
            state        <= nios_pkg::IDLE;
          end
          default: state <= nios_pkg::IDLE;
        endcase
      end
    end
  end

  // DAC 0 ends up right after the OMR in the burst.
  always_comb begin
    for (int i = 0; i < `DAC_COUNT; i++) begin
      dac_flat[DAC_FLAT-1-i*`DAC_BITS -: `DAC_BITS] = dac[i];
    end
  end

  always_comb begin
    if (start[LOAD_CH]) begin
      frame.bits = {omr, dac_flat};
      frame.len  = `LEN_BITS'(`FRAME_BITS);
      frame.m    = medipix_pkg::M_LOAD_DACS;
    end else begin
      frame.bits = {omr, {(`FRAME_BITS-`OMR_BITS){1'b0}}};
      frame.len  = `LEN_BITS'(`OMR_BITS);
      frame.m    = medipix_pkg::M_SET_OMR;
    end
  end

endmodule

//--- burst_channel.sv
`timescale 1ns/1ns
`include "mdpx_defs.svh"

module burst_channel (
  input  logic                      clk_nios,
  input  logic                      reset,
  input  logic                      start,
  input  medipix_pkg::burst_frame_t frame,
  burst_if.channel                  pins
);

  logic [`FRAME_BITS-1:0] shift;
  logic [`LEN_BITS-1:0]   bits_left;
  logic                   phase; // low half of a bit when clear.
  logic                   active;
  medipix_pkg::m_code_t   code;

  always_ff @(posedge clk_nios) begin
    if (reset) begin
      active    <= 1'b0;
      phase     <= 1'b0;
      bits_left <= '0;
    end else if (start && !active) begin
      active    <= 1'b1;
      phase     <= 1'b0;
      bits_left <= frame.len;
    end else if (active) begin
      phase <= ~phase;
      if (phase) begin
        bits_left <= bits_left - 1'b1;
        if (bits_left == `LEN_BITS'(1)) begin
          active <= 1'b0; // last high phase done.
        end
      end
    end
  end

  // next bit moves up at the end of each high phase.
  always_ff @(posedge clk_nios) begin
    if (start && !active) begin
      shift <= frame.bits;
      code  <= frame.m;
    end else if (active && phase) begin
      shift <= shift << 1;
    end
  end

  assign pins.clk_mdpx  = phase;
  assign pins.data_mdpx = active & shift[`FRAME_BITS-1];
  assign pins.en_mdpx   = active;
  assign pins.busy      = active;
  assign pins.m         = active ? code : medipix_pkg::M_IDLE;

endmodule

//--- output_select.sv
`timescale 1ns/1ns
`include "mdpx_defs.svh"

module output_select (
  burst_if.sink                 chan [`N_CHANNELS],
  output logic                  clk_mdpx,
  output logic                  data_mdpx,
  output logic                  en_mdpx,
  output medipix_pkg::m_code_t  m
);

  logic [`N_CHANNELS-1:0] busy;
  logic [`N_CHANNELS-1:0] clk_v;
  logic [`N_CHANNELS-1:0] data_v;
  logic [`N_CHANNELS-1:0] en_v;
  medipix_pkg::m_code_t   m_v [`N_CHANNELS];

  genvar g;
  generate
    for (g = 0; g < `N_CHANNELS; g++) begin : g_unpack
      assign busy[g]   = chan[g].busy;
      assign clk_v[g]  = chan[g].clk_mdpx;
      assign data_v[g] = chan[g].data_mdpx;
      assign en_v[g]   = chan[g].en_mdpx;
      assign m_v[g]    = chan[g].m;
    end
  endgenerate

  // scanned from the top so the lowest busy channel wins.
  always_comb begin
    clk_mdpx  = 1'b0;
    data_mdpx = 1'b0;
    en_mdpx   = 1'b0;
    m         = medipix_pkg::M_IDLE;
    for (int i = `N_CHANNELS - 1; i >= 0; i--) begin
      if (busy[i]) begin
        clk_mdpx  = clk_v[i];
        data_mdpx = data_v[i];
        en_mdpx   = en_v[i];
        m         = m_v[i];
      end
    end
  end

endmodule

//--- medipix_bridge.sv
`timescale 1ns/1ns
`include "mdpx_defs.svh"

module medipix_bridge (
  input  logic       clk_nios,
  input  logic       reset,
  input  logic       en,
  input  logic       sync,
  input  logic [7:0] data,
  output logic       clk_mdpx,
  output logic       data_mdpx,
  output logic       en_mdpx,
  output logic [2:0] m
);

  logic [`N_CHANNELS-1:0]    start;
  medipix_pkg::burst_frame_t frame;

  // channel 0 sends OMR writes, channel 1 the DAC loads.
  burst_if chan_if [`N_CHANNELS] ();

  command_decoder decoder_i (
    .clk_nios (clk_nios),
    .reset    (reset),
    .en       (en),
    .sync     (sync),
    .data     (data),
    .chan     (chan_if),
    .start    (start),
    .frame    (frame)
  );

  genvar g;
  generate
    for (g = 0; g < `N_CHANNELS; g++) begin : g_channel
      burst_channel channel_i (
        .clk_nios (clk_nios),
        .reset    (reset),
        .start    (start[g]),
        .frame    (frame),
        .pins     (chan_if[g])
      );
    end
  endgenerate

  output_select select_i (
    .chan      (chan_if),
    .clk_mdpx  (clk_mdpx),
    .data_mdpx (data_mdpx),
    .en_mdpx   (en_mdpx),
    .m         (m)
  );

endmodule

//--- medipix_bridge_chk.sv
`timescale 1ns/1ns

module medipix_bridge_chk (
  input logic       clk_nios,
  input logic       reset,
  input logic       en,
  input logic       sync,
  input logic       clk_mdpx,
  input logic       data_mdpx,
  input logic       en_mdpx,
  input logic [2:0] m
);

  logic cmd_seen; // set by the first opcode after reset.
  int   n_failures = 0; // failed assertions so far.

  always_ff @(posedge clk_nios) begin
    if (reset) begin
      cmd_seen <= 1'b0;
    end else if (en && sync) begin
      cmd_seen <= 1'b1;
    end
  end

  clk_low_when_idle: assert property (@(posedge clk_nios) disable iff (reset)
    !en_mdpx |-> !clk_mdpx)
    else begin
      $error("chip clock high outside a burst");
      n_failures++;
    end

  m_idle_when_idle: assert property (@(posedge clk_nios) disable iff (reset)
    !en_mdpx |-> m == medipix_pkg::M_IDLE)
    else begin
      $error("m not idle outside a burst");
      n_failures++;
    end

  // the chip samples data while its clock is high.
  data_stable_high: assert property (@(posedge clk_nios) disable iff (reset)
    $rose(clk_mdpx) |-> $stable(data_mdpx))
    else begin
      $error("chip data moved in high phase");
      n_failures++;
    end

  quiet_after_reset: assert property (@(posedge clk_nios) disable iff (reset)
    !cmd_seen |-> !en_mdpx)
    else begin
      $error("burst started before any command");
      n_failures++;
    end

endmodule

bind medipix_bridge medipix_bridge_chk chk_i (
  .clk_nios  (clk_nios),
  .reset     (reset),
  .en        (en),
  .sync      (sync),
  .clk_mdpx  (clk_mdpx),
  .data_mdpx (data_mdpx),
  .en_mdpx   (en_mdpx),
  .m         (m)
);

//--- medipix_bridge_tb.sv
`timescale 1ns/1ns
`include "mdpx_defs.svh"

module medipix_bridge_tb;

  localparam int N_RAND = 60;
  // each command costs at most one full burst plus its bytes and gaps.
  localparam int TIMEOUT_CYCLES = 2 * (N_RAND + 12) * (2 * `FRAME_BITS + 24) + 200;

  logic       clk_nios;
  logic       reset;
  logic       en;
  logic       sync;
  logic [7:0] data;
  logic       clk_mdpx;
  logic       data_mdpx;
  logic       en_mdpx;
  logic [2:0] m;

  logic [31:0] lcg_state = 32'h41301435;
  int cycle = 0;
  int drv_cycle = 0; // follows cycle, counted by the stimulus process.
  int errors = 0;
  int n_tests = 0;
  int n_seen = 0;
  int n_expected = 0;
  string test_name = "reset";

  logic [`OMR_BITS-1:0] omr_model;
  logic [`OMR_BITS-1:0] omr_acc;
  logic [`DAC_BITS-1:0] dac_model [`DAC_COUNT];
  int mode; // 0 outside a command, 1 OMR bytes, 2 DAC index, 3 DAC value.
  int omr_count;
  int dac_sel;
  int busy_until;

  logic [`FRAME_BITS-1:0] exp_bits [$];
  int                     exp_len [$];
  logic [2:0]             exp_m [$];
  int                     exp_rise [$];
  logic [`FRAME_BITS-1:0] got_bits;
  int                     got_len;
  logic [2:0]             got_m;
  int                     rise_cycle;
  logic                   en_prev = 1'b0;
  logic                   clk_prev = 1'b0;

  medipix_bridge dut_i (
    .clk_nios  (clk_nios),
    .reset     (reset),
    .en        (en),
    .sync      (sync),
    .data      (data),
    .clk_mdpx  (clk_mdpx),
    .data_mdpx (data_mdpx),
    .en_mdpx   (en_mdpx),
    .m         (m)
  );

  initial begin
    clk_nios = 1'b0;
    forever #50 clk_nios = ~clk_nios;
  end

  always @(posedge clk_nios) cycle = cycle + 1;

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16]) % n;
  endfunction

  task automatic report_mismatch(input string what, input logic [127:0] exp_v,
                                 input logic [127:0] act_v);
    $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  // chip pins are sampled in the middle of each cycle where they are settled.
  always @(negedge clk_nios) begin
    if (en_mdpx && !en_prev) begin
      rise_cycle = cycle;
      got_bits = '0;
      got_len = 0;
    end
    if (en_mdpx && clk_mdpx && !clk_prev) begin
      if (got_len < `FRAME_BITS) got_bits[`FRAME_BITS-1-got_len] = data_mdpx;
      got_len++;
      got_m = m;
    end
    if (!en_mdpx && en_prev && !reset) begin
      if (exp_len.size() == 0) begin
        $display("error in %s: a burst appeared that no command should start", test_name);
        errors++;
      end else begin
        if (got_bits !== exp_bits[0]) report_mismatch("bits", exp_bits[0], got_bits);
        if (got_len != exp_len[0]) report_mismatch("length", exp_len[0], got_len);
        if (got_m !== exp_m[0]) report_mismatch("m code", exp_m[0], got_m);
        if (rise_cycle != exp_rise[0]) begin
          report_mismatch("en rise cycle", exp_rise[0], rise_cycle);
        end
        if (cycle - rise_cycle != 2 * exp_len[0]) begin
          report_mismatch("en cycles", 2 * exp_len[0], cycle - rise_cycle);
        end
        void'(exp_bits.pop_front());
        void'(exp_len.pop_front());
        void'(exp_m.pop_front());
        void'(exp_rise.pop_front());
        n_seen++;
      end
    end
    en_prev = en_mdpx;
    clk_prev = clk_mdpx;
  end

  // a burst starts 2 cycles after the byte and keeps the DUT busy for 2 cycles per bit.
  task automatic expect_burst(input logic [`FRAME_BITS-1:0] bits, input int len,
                              input logic [2:0] code, input int at);
    exp_bits.push_back(bits);
    exp_len.push_back(len);
    exp_m.push_back(code);
    exp_rise.push_back(at + 2);
    busy_until = at + 2 + 2 * len;
    n_expected++;
  endtask

  // mirrors the host protocol for one byte sampled with en high at cycle at.
  task automatic model_byte(input logic s, input logic [7:0] d, input int at);
    logic [`FRAME_BITS-1:0] load;
    if (s) begin
      mode = 0;
      omr_count = 0;
      if (d == 8'h01) mode = 1;
      if (d == 8'h02) mode = 2;
      if (d == 8'h03 && at > busy_until) begin
        load = {omr_model, {(`FRAME_BITS-`OMR_BITS){1'b0}}};
        for (int i = 0; i < `DAC_COUNT; i++) begin
          load[`FRAME_BITS-`OMR_BITS-1-i*`DAC_BITS -: `DAC_BITS] = dac_model[i];
        end
        expect_burst(load, `FRAME_BITS, 3'b100, at);
      end
    end else if (mode == 1) begin
      omr_acc = {omr_acc[`OMR_BITS-9:0], d};
      omr_count++;
      if (omr_count == `OMR_BITS / 8) begin
        mode = 0;
        if (at > busy_until) begin // dropped while any burst is pending.
          omr_model = omr_acc;
          expect_burst({omr_acc, {(`FRAME_BITS-`OMR_BITS){1'b0}}}, `OMR_BITS, 3'b011, at);
        end
      end
    end else if (mode == 2) begin
      dac_sel = d % `DAC_COUNT;
      mode = 3;
    end else if (mode == 3) begin
      dac_model[dac_sel] = d;
      mode = 0;
    end
  endtask

  task automatic tick();
    @(posedge clk_nios);
    drv_cycle++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      tick();
      en   <= 1'b0;
      sync <= rand_below(2); // noise that the DUT must ignore.
      data <= rand_below(256);
    end
  endtask

  task automatic send(input logic s, input logic [7:0] d);
    tick();
    en   <= 1'b1;
    sync <= s;
    data <= d;
    model_byte(s, d, drv_cycle + 1);
  endtask

  task automatic wait_idle();
    do idle(1); while (n_seen != n_expected || drv_cycle <= busy_until + 1);
  endtask

  task automatic finish_test(input int errors_before);
    wait_idle();
    n_tests++;
    if (errors == errors_before) $display("test %s: ok", test_name);
    else $display("test %s: %0d errors", test_name, errors - errors_before);
  endtask

  task automatic send_omr_write(input int n_bytes);
    send(1'b1, 8'h01);
    repeat (n_bytes) send(1'b0, rand_below(256));
  endtask

  initial begin
    int e0;
    int kind;
    reset <= 1'b1;
    en    <= 1'b0;
    sync  <= 1'b0;
    data  <= 8'h00;
    omr_model = '0;
    omr_acc = '0;
    mode = 0;
    omr_count = 0;
    dac_sel = 0;
    busy_until = 0;
    for (int i = 0; i < `DAC_COUNT; i++) dac_model[i] = '0;
    tick();
    tick();
    reset <= 1'b0;

    test_name = "reset_idle";
    e0 = errors;
    repeat (10) begin
      idle(1);
      @(negedge clk_nios);
      if (clk_mdpx !== 1'b0 || data_mdpx !== 1'b0 || en_mdpx !== 1'b0) begin
        $display("error in %s: chip pins are not low before the first command", test_name);
        errors++;
      end
      if (m !== 3'b000) report_mismatch("m", 3'b000, m);
    end
    finish_test(e0);

    test_name = "omr_write";
    e0 = errors;
    send_omr_write(6);
    finish_test(e0);

    test_name = "dac_load";
    e0 = errors;
    for (int i = 0; i < `DAC_COUNT; i++) begin
      send(1'b1, 8'h02);
      send(1'b0, i);
      send(1'b0, rand_below(256));
    end
    send(1'b1, 8'h03);
    finish_test(e0);

    test_name = "busy_drop";
    e0 = errors;
    send_omr_write(6);
    send_omr_write(6); // lands while the first burst runs.
    send(1'b1, 8'h03);
    wait_idle();
    send(1'b1, 8'h03);
    finish_test(e0);

    test_name = "abandon";
    e0 = errors;
    send(1'b1, 8'h02);
    send(1'b0, 8'h05);
    send_omr_write(3);
    send_omr_write(6);
    wait_idle();
    send(1'b1, 8'h03);
    finish_test(e0);

    test_name = "random";
    e0 = errors;
    repeat (N_RAND) begin
      idle(rand_below(4));
      if (rand_below(3) == 0) wait_idle();
      kind = rand_below(6);
      if (kind < 2) begin
        send_omr_write(rand_below(4) == 0 ? rand_below(6) : 6);
      end else if (kind == 2) begin
        send(1'b1, 8'h02);
        send(1'b0, rand_below(256));
        send(1'b0, rand_below(256));
      end else if (kind == 3) begin
        send(1'b1, 8'h03);
      end else if (kind == 4) begin
        send(1'b1, 4 + rand_below(252)); // unknown opcode.
      end else begin
        send(1'b0, rand_below(256));
      end
    end
    finish_test(e0);

    if (n_seen != n_expected) begin
      $display("error: %0d bursts expected but %0d seen", n_expected, n_seen);
      errors++;
    end
    if (dut_i.chk_i.n_failures != 0) begin
      $display("error: %0d assertions on the chip pins failed", dut_i.chk_i.n_failures);
      errors += dut_i.chk_i.n_failures;
    end
    $display("%0d tests, %0d bursts, %0d errors", n_tests, n_seen, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+.
medipix_pkg.sv
nios_pkg.sv
burst_if.sv
command_decoder.sv
burst_channel.sv
output_select.sv
medipix_bridge.sv
medipix_bridge_chk.sv
medipix_bridge_tb.sv

//--- Bender.yml
package:
  name: medipix_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - medipix_pkg.sv
      - nios_pkg.sv
      - burst_if.sv
      - command_decoder.sv
      - burst_channel.sv
      - output_select.sv
      - medipix_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - medipix_bridge_chk.sv
      - medipix_bridge_tb.sv
